/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dma
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx 'PASS: all tests' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hdl/dma.sv */
`timescale 1ns/1ps

module dma (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Register port for the CPU
  input  dma_bus_pkg::bus_req_t reg_req_i,
  output dma_bus_pkg::bus_rsp_t reg_rsp_o,
  // Source side, reads only
  output dma_bus_pkg::bus_req_t rd_req_o,
  input  dma_bus_pkg::bus_rsp_t rd_rsp_i,
  // Destination side, writes only
  output dma_bus_pkg::bus_req_t wr_req_o,
  input  dma_bus_pkg::bus_rsp_t wr_rsp_i,
  output logic                  dma_irq_o
);
  import dma_bus_pkg::*;
  import dma_reg_pkg::*;

  dma_cfg_t          cfg;
  logic              start;
  logic              abort;
  logic              push;
  logic              pop;
  logic [DataW-1:0]  push_data;
  logic [DataW-1:0]  pop_data;
  logic              full;
  logic              almost_full;
  logic              empty;
  logic [CountW-1:0] rd_count;
  logic [CountW-1:0] wr_count;
  logic              busy;
  logic              done;

  dma_regs i_dma_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .reg_req_i  (reg_req_i),
    .reg_rsp_o  (reg_rsp_o),
    .rd_count_i (rd_count),
    .wr_count_i (wr_count),
    .busy_i     (busy),
    .done_i     (done),
    .cfg_o      (cfg),
    .start_o    (start),
    .abort_o    (abort),
    .irq_o      (dma_irq_o)
  );

  dma_reader i_dma_reader (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg_i         (cfg),
    .start_i       (start),
    .abort_i       (abort),
    .rd_req_o      (rd_req_o),
    .rd_rsp_i      (rd_rsp_i),
    .full_i        (full),
    .almost_full_i (almost_full),
    .push_o        (push),
    .push_data_o   (push_data),
    .rd_count_o    (rd_count)
  );

  dma_fifo #(
    .Depth (2)
  ) i_dma_fifo (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .push_i        (push),
    .push_data_i   (push_data),
    .pop_i         (pop),
    .pop_data_o    (pop_data),
    .full_o        (full),
    .almost_full_o (almost_full),
    .empty_o       (empty)
  );

  dma_writer i_dma_writer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg_i      (cfg),
    .start_i    (start),
    .abort_i    (abort),
    .empty_i    (empty),
    .pop_data_i (pop_data),
    .pop_o      (pop),
    .wr_req_o   (wr_req_o),
    .wr_rsp_i   (wr_rsp_i),
    .wr_count_o (wr_count),
    .busy_o     (busy),
    .done_o     (done)
  );

endmodule

/* hdl/dma_bus_pkg.sv */
package dma_bus_pkg;

  // Address and data width shared by every bus port
  localparam int unsigned AddrW = 32;
  localparam int unsigned DataW = 32;

  // One enable per byte lane
  localparam int unsigned StrbW = DataW / 8;

  // Request from a manager to a subordinate
  // The fields stay stable from the rise of req until the cycle with gnt
  typedef struct packed {
    logic             req;
    logic             we;
    logic [AddrW-1:0] addr;
    logic [StrbW-1:0] be;
    logic [DataW-1:0] wdata;
  } bus_req_t;

  // Response of a subordinate
  // gnt accepts the request, rvalid marks the data phase that follows
  typedef struct packed {
    logic             gnt;
    logic             rvalid;
    logic             err;
    logic [DataW-1:0] rdata;
  } bus_rsp_t;

endpackage

/* hdl/dma_fifo.sv */
`timescale 1ns/1ps

module dma_fifo #(
  parameter int unsigned Depth = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          push_i,
  input  logic [dma_bus_pkg::DataW-1:0] push_data_i,
  input  logic                          pop_i,
  output logic [dma_bus_pkg::DataW-1:0] pop_data_o,
  output logic                          full_o,
  output logic                          almost_full_o,
  output logic                          empty_o
);
  import dma_bus_pkg::*;

  // Depth of at least 2, need not be a power of two
  localparam int unsigned PtrW = $clog2(Depth);
  localparam int unsigned CntW = $clog2(Depth + 1);

  logic [DataW-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]  count_q;
  logic             do_push, do_pop;

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty_o       = (count_q == '0);
  assign full_o        = (count_q == CntW'(Depth));
  assign almost_full_o = (count_q >= CntW'(Depth - 1));
  assign pop_data_o    = mem_q[rd_ptr_q];

  // A push into a full buffer is taken only when a pop frees the slot
  assign do_pop  = pop_i && !empty_o;
  assign do_push = push_i && (!full_o || do_pop);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + CntW'(do_push) - CntW'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

/* hdl/dma_reader.sv */
`timescale 1ns/1ps

module dma_reader (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  dma_reg_pkg::dma_cfg_t          cfg_i,
  input  logic                           start_i,
  input  logic                           abort_i,
  output dma_bus_pkg::bus_req_t          rd_req_o,
  input  dma_bus_pkg::bus_rsp_t          rd_rsp_i,
  input  logic                           full_i,
  input  logic                           almost_full_i,
  output logic                           push_o,
  output logic [dma_bus_pkg::DataW-1:0]  push_data_o,
  output logic [dma_reg_pkg::CountW-1:0] rd_count_o
);
  import dma_bus_pkg::*;
  import dma_reg_pkg::*;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT_GNT,
    RD_WAIT_RVALID,
    RD_WAIT_SPACE
  } rd_state_e;

  rd_state_e         state_d, state_q;
  logic [CountW-1:0] count_d, count_q;
  logic              req_d, req_q;
  logic [AddrW-1:0]  addr_d, addr_q;
  logic              push_d, push_q;
  logic [DataW-1:0]  data_d, data_q;
  logic [AddrW-1:0]  addr_next;
  logic              room;

  // Source address of the following item
  assign addr_next = !cfg_i.inc_src            ? addr_q :
                     (cfg_i.size == XFER_BYTE) ? addr_q + AddrW'(1) :
                                                 addr_q + AddrW'(4);

  // Room for one more item, counting a push still on its way into the FIFO
  assign room = push_q ? !almost_full_i : !full_i;

  // ------------------------------------------------------------------------
  // Fetch FSM
  // ------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    count_d = count_q;
    req_d   = 1'b0;
    addr_d  = addr_q;
    push_d  = 1'b0;
    data_d  = data_q;

    if (abort_i) begin
      state_d = RD_IDLE;
    end else begin
      case (state_q)
        RD_IDLE: begin
          if (start_i) begin
            addr_d  = cfg_i.src_base + AddrW'(cfg_i.src_offset);
            count_d = CountW'(1);
            req_d   = 1'b1;
            state_d = RD_WAIT_GNT;
          end
        end
        RD_WAIT_GNT: begin
          if (rd_rsp_i.gnt) begin
            state_d = RD_WAIT_RVALID;
          end else begin
            req_d = 1'b1;
          end
        end
        RD_WAIT_RVALID: begin
          if (rd_rsp_i.rvalid && rd_rsp_i.err) begin
            // Fetch the same item again
            req_d   = 1'b1;
            state_d = RD_WAIT_GNT;
          end else if (rd_rsp_i.rvalid) begin
            push_d = 1'b1;
            if (cfg_i.size == XFER_BYTE) begin
              data_d = DataW'(rd_rsp_i.rdata[{addr_q[1:0], 3'b000} +: 8]);
            end else begin
              data_d = rd_rsp_i.rdata;
            end
            count_d = count_q + 1'b1;
            addr_d  = addr_next;
            if (count_q == cfg_i.num_transfers) begin
              state_d = RD_IDLE;
            end else if (!almost_full_i) begin
              req_d   = 1'b1;
              state_d = RD_WAIT_GNT;
            end else begin
              state_d = RD_WAIT_SPACE;
            end
          end
        end
        RD_WAIT_SPACE: begin
          if (room) begin
            req_d   = 1'b1;
            state_d = RD_WAIT_GNT;
          end
        end
        default: state_d = RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= RD_IDLE;
      count_q <= '0;
      req_q   <= 1'b0;
      push_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      count_q <= count_d;
      req_q   <= req_d;
      push_q  <= push_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    data_q <= data_d;
  end

  assign rd_req_o    = '{req: req_q, we: 1'b0, addr: addr_q, be: {StrbW{1'b1}}, wdata: '0};
  assign push_o      = push_q;
  assign push_data_o = data_q;
  assign rd_count_o  = count_q;

endmodule

/* hdl/dma_reg_pkg.sv */
package dma_reg_pkg;

  // Width of the register offset within the DMA window
  localparam int unsigned RegAddrW = 8;

  // Register map in byte offsets
  localparam logic [RegAddrW-1:0] RegSrcAddr  = 8'h00;
  localparam logic [RegAddrW-1:0] RegDstAddr  = 8'h04;
  localparam logic [RegAddrW-1:0] RegControl  = 8'h08;
  localparam logic [RegAddrW-1:0] RegAbort    = 8'h10;
  localparam logic [RegAddrW-1:0] RegActivate = 8'h14;
  localparam logic [RegAddrW-1:0] RegStatus   = 8'h18;

  // Transfer counters and offset fields
  localparam int unsigned CountW  = 11;
  localparam int unsigned OffsetW = 8;

  typedef enum logic {
    XFER_WORD = 1'b0,
    XFER_BYTE = 1'b1
  } xfer_size_t;

  // Configuration seen by the reader and the writer
  typedef struct packed {
    logic [dma_bus_pkg::AddrW-1:0] src_base;
    logic [dma_bus_pkg::AddrW-1:0] dst_base;
    logic [OffsetW-1:0]            src_offset;
    logic [OffsetW-1:0]            dst_offset;
    logic [CountW-1:0]             num_transfers;
    logic                          irq_enable;
    logic                          inc_src;
    logic                          inc_dst;
    xfer_size_t                    size;
  } dma_cfg_t;

  // Control word as the CPU writes and reads it
  typedef struct packed {
    logic [OffsetW-1:0] src_offset;
    logic [OffsetW-1:0] dst_offset;
    logic [CountW-1:0]  num_transfers;
    logic               irq_enable;
    logic               inc_src;
    logic               inc_dst;
    xfer_size_t         size;
    logic               activate;
  } ctrl_reg_t;

endpackage

/* hdl/dma_regs.sv */
`timescale 1ns/1ps

module dma_regs (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  dma_bus_pkg::bus_req_t          reg_req_i,
  output dma_bus_pkg::bus_rsp_t          reg_rsp_o,
  input  logic [dma_reg_pkg::CountW-1:0] rd_count_i,
  input  logic [dma_reg_pkg::CountW-1:0] wr_count_i,
  input  logic                           busy_i,
  input  logic                           done_i,
  output dma_reg_pkg::dma_cfg_t          cfg_o,
  output logic                           start_o,
  output logic                           abort_o,
  output logic                           irq_o
);
  import dma_bus_pkg::*;
  import dma_reg_pkg::*;

  // Request captured in the grant cycle
  logic                req_q;
  logic                we_q;
  logic [RegAddrW-1:0] word_idx_q;
  logic [DataW-1:0]    wdata_q;

  dma_cfg_t            cfg_d, cfg_q;
  logic                start_d, start_q;
  logic                abort_d, abort_q;
  logic                irq_q;

  logic                active;
  logic                in_page;
  logic [RegAddrW-1:0] reg_off;
  ctrl_reg_t           ctrl_wr;
  ctrl_reg_t           ctrl_rd;
  logic [DataW-1:0]    rsp_rdata;
  logic                rsp_err;

  // ------------------------------------------------------------------------
  // Request capture
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else begin
      req_q <= reg_req_i.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_req_i.req) begin
      we_q       <= reg_req_i.we;
      word_idx_q <= reg_req_i.addr[9:2];
      wdata_q    <= reg_req_i.wdata;
    end
  end

  // Word index 9:2 maps to byte offsets, only the first 64 words hold registers
  assign reg_off = {word_idx_q[RegAddrW-3:0], 2'b00};
  assign in_page = (word_idx_q[RegAddrW-1:RegAddrW-2] == 2'b00);

  // Engine counts as running from the start pulse on
  assign active  = busy_i | start_q;

  assign ctrl_wr = ctrl_reg_t'(wdata_q);
  assign ctrl_rd = '{
    src_offset:    cfg_q.src_offset,
    dst_offset:    cfg_q.dst_offset,
    num_transfers: cfg_q.num_transfers,
    irq_enable:    cfg_q.irq_enable,
    inc_src:       cfg_q.inc_src,
    inc_dst:       cfg_q.inc_dst,
    size:          cfg_q.size,
    activate:      active
  };

  // ------------------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------------------

  always_comb begin
    cfg_d     = cfg_q;
    start_d   = 1'b0;
    abort_d   = 1'b0;
    rsp_rdata = '0;
    rsp_err   = 1'b0;

    if (req_q) begin
      if (!in_page) begin
        rsp_err = 1'b1;
      end else if (we_q) begin
        // Only the abort register takes writes while a run is going on
        if (active && reg_off != RegAbort) begin
          rsp_err = 1'b1;
        end else begin
          case (reg_off)
            RegSrcAddr: cfg_d.src_base = wdata_q;
            RegDstAddr: cfg_d.dst_base = wdata_q;
            RegControl: begin
              cfg_d.src_offset    = ctrl_wr.src_offset;
              cfg_d.dst_offset    = ctrl_wr.dst_offset;
              cfg_d.num_transfers = ctrl_wr.num_transfers;
              cfg_d.irq_enable    = ctrl_wr.irq_enable;
              cfg_d.inc_src       = ctrl_wr.inc_src;
              cfg_d.inc_dst       = ctrl_wr.inc_dst;
              cfg_d.size          = ctrl_wr.size;
              start_d             = ctrl_wr.activate;
            end
            RegAbort:    abort_d = 1'b1;
            RegActivate: start_d = 1'b1;
            default:     rsp_err = 1'b1;
          endcase
        end
      end else begin
        case (reg_off)
          RegSrcAddr:  rsp_rdata = cfg_q.src_base;
          RegDstAddr:  rsp_rdata = cfg_q.dst_base;
          RegControl:  rsp_rdata = ctrl_rd;
          RegAbort:    rsp_rdata = '0;
          RegActivate: rsp_rdata = DataW'(active);
          RegStatus: begin
            rsp_rdata = {rd_count_i, wr_count_i, {(DataW - 2 * CountW - 1){1'b0}}, active};
          end
          default:     rsp_err = 1'b1;
        endcase
      end
    end
  end

  // ------------------------------------------------------------------------
  // Configuration, pulses and interrupt
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cfg_q   <= '0;
      start_q <= 1'b0;
      abort_q <= 1'b0;
      irq_q   <= 1'b0;
    end else begin
      cfg_q   <= cfg_d;
      start_q <= start_d;
      abort_q <= abort_d;
      // A finished run wins over a register access in the same cycle
      if (done_i && cfg_q.irq_enable) begin
        irq_q <= 1'b1;
      end else if (req_q) begin
        irq_q <= 1'b0;
      end
    end
  end

  assign reg_rsp_o = '{gnt: reg_req_i.req, rvalid: req_q, err: rsp_err, rdata: rsp_rdata};
  assign cfg_o     = cfg_q;
  assign start_o   = start_q;
  assign abort_o   = abort_q;
  assign irq_o     = irq_q;

endmodule

/* hdl/dma_writer.sv */
`timescale 1ns/1ps

module dma_writer (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  dma_reg_pkg::dma_cfg_t          cfg_i,
  input  logic                           start_i,
  input  logic                           abort_i,
  input  logic                           empty_i,
  input  logic [dma_bus_pkg::DataW-1:0]  pop_data_i,
  output logic                           pop_o,
  output dma_bus_pkg::bus_req_t          wr_req_o,
  input  dma_bus_pkg::bus_rsp_t          wr_rsp_i,
  output logic [dma_reg_pkg::CountW-1:0] wr_count_o,
  output logic                           busy_o,
  output logic                           done_o
);
  import dma_bus_pkg::*;
  import dma_reg_pkg::*;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_WAIT_INPUT,
    WR_WAIT_GNT
  } wr_state_e;

  wr_state_e         state_d, state_q;
  logic [CountW-1:0] count_d, count_q;
  logic              req_d, req_q;
  logic [AddrW-1:0]  addr_d, addr_q;
  logic [StrbW-1:0]  be_d, be_q;
  logic [DataW-1:0]  wdata_d, wdata_q;
  logic              done_d, done_q;
  logic              load;
  logic [AddrW-1:0]  addr_next;
  logic [AddrW-1:0]  load_addr;

  assign addr_next = !cfg_i.inc_dst            ? addr_q :
                     (cfg_i.size == XFER_BYTE) ? addr_q + AddrW'(1) :
                                                 addr_q + AddrW'(4);

  // After a grant the next item goes to the advanced address
  assign load_addr = (state_q == WR_WAIT_GNT) ? addr_next : addr_q;

  // ------------------------------------------------------------------------
  // Store FSM
  // ------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    count_d = count_q;
    req_d   = 1'b0;
    addr_d  = addr_q;
    be_d    = be_q;
    wdata_d = wdata_q;
    done_d  = 1'b0;
    pop_o   = 1'b0;
    load    = 1'b0;

    if (abort_i) begin
      state_d = WR_IDLE;
    end else begin
      case (state_q)
        WR_IDLE: begin
          if (start_i) begin
            addr_d  = cfg_i.dst_base + AddrW'(cfg_i.dst_offset);
            count_d = CountW'(1);
            state_d = WR_WAIT_INPUT;
          end else begin
            // Items left over from an aborted run are dropped here
            pop_o = !empty_i;
          end
        end
        WR_WAIT_INPUT: begin
          load = !empty_i;
        end
        WR_WAIT_GNT: begin
          if (wr_rsp_i.gnt) begin
            count_d = count_q + 1'b1;
            addr_d  = addr_next;
            if (count_q == cfg_i.num_transfers) begin
              done_d  = 1'b1;
              state_d = WR_IDLE;
            end else if (!empty_i) begin
              load = 1'b1;
            end else begin
              state_d = WR_WAIT_INPUT;
            end
          end else begin
            req_d = 1'b1;
          end
        end
        default: state_d = WR_IDLE;
      endcase
    end

    // Take the next item from the FIFO and place it on the lanes
    if (load) begin
      pop_o   = 1'b1;
      req_d   = 1'b1;
      state_d = WR_WAIT_GNT;
      if (cfg_i.size == XFER_BYTE) begin
        wdata_d = {StrbW{pop_data_i[7:0]}};
        be_d    = StrbW'(1) << load_addr[1:0];
      end else begin
        wdata_d = pop_data_i;
        be_d    = {StrbW{1'b1}};
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= WR_IDLE;
      count_q <= '0;
      req_q   <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      count_q <= count_d;
      req_q   <= req_d;
      done_q  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q  <= addr_d;
    be_q    <= be_d;
    wdata_q <= wdata_d;
  end

  assign wr_req_o   = '{req: req_q, we: 1'b1, addr: addr_q, be: be_q, wdata: wdata_q};
  assign wr_count_o = count_q;
  assign busy_o     = (state_q != WR_IDLE);
  assign done_o     = done_q;

endmodule

/* sources.f */
hdl/dma_bus_pkg.sv
hdl/dma_reg_pkg.sv
hdl/dma_regs.sv
hdl/dma_reader.sv
hdl/dma_fifo.sv
hdl/dma_writer.sv
hdl/dma.sv
testbench/tb_clock.sv
testbench/tb_mem_model.sv
testbench/tb_dma.sv

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int HalfPeriod  = 4,
  parameter int ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // Reset held low over the first rising edges
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* testbench/tb_dma.sv */
`timescale 1ns/1ps

module tb_dma;
  import dma_bus_pkg::*;
  import dma_reg_pkg::*;

  localparam int Words      = 256;
  localparam int CycleLimit = 1000;
  localparam int PollLimit  = 500;

  logic     clk;
  logic     rst_n;
  bus_req_t reg_req;
  bus_rsp_t reg_rsp;
  bus_req_t rd_req;
  bus_rsp_t rd_rsp;
  bus_req_t wr_req;
  bus_rsp_t wr_rsp;
  logic     dma_irq;

  int               checks;
  int               errors;
  int               timeouts;
  logic [DataW-1:0] rsp_data;
  logic             rsp_err;
  logic [DataW-1:0] snap [Words];
  logic [DataW-1:0] expect_mem [Words];

  tb_clock i_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  dma i_dma (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .reg_req_i (reg_req),
    .reg_rsp_o (reg_rsp),
    .rd_req_o  (rd_req),
    .rd_rsp_i  (rd_rsp),
    .wr_req_o  (wr_req),
    .wr_rsp_i  (wr_rsp),
    .dma_irq_o (dma_irq)
  );

  tb_mem_model i_mem (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .rd_req_i (rd_req),
    .rd_rsp_o (rd_rsp),
    .wr_req_i (wr_req),
    .wr_rsp_o (wr_rsp)
  );

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  task automatic check_value(input string name, input logic [DataW-1:0] exp,
                             input logic [DataW-1:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // Counters start at 1 and end one past the item count
  task automatic check_status(input string name, input int items);
    check_flag({name, " active"}, 1'b0, rsp_data[0]);
    check_value({name, " read count"}, DataW'(items + 1), DataW'(rsp_data[31:21]));
    check_value({name, " write count"}, DataW'(items + 1), DataW'(rsp_data[20:10]));
  endtask

  // --------------------------------------------------------------------------
  // Register port
  // --------------------------------------------------------------------------

  task automatic reg_access(input logic we, input logic [RegAddrW-1:0] off,
                            input logic [DataW-1:0] wdata);
    int cycles;
    @(posedge clk);
    reg_req <= '{req: 1'b1, we: we, addr: AddrW'(off), be: '1, wdata: wdata};
    cycles = 0;
    @(negedge clk);
    while (!reg_rsp.gnt && cycles < CycleLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (!reg_rsp.gnt) begin
      timeouts++;
      $display("Register access at offset %h was not granted", off);
    end
    @(posedge clk);
    reg_req.req <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!reg_rsp.rvalid && cycles < CycleLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (!reg_rsp.rvalid) begin
      timeouts++;
      $display("Register access at offset %h got no response", off);
    end
    rsp_err  = reg_rsp.err;
    rsp_data = reg_rsp.rdata;
  endtask

  // Layout from high to low, activate set in bit 0
  function automatic logic [DataW-1:0] ctrl_word(input logic [7:0] src_off,
      input logic [7:0] dst_off, input logic [10:0] num, input logic irq,
      input logic inc_src, input logic inc_dst, input logic byte_size);
    return {src_off, dst_off, num, irq, inc_src, inc_dst, byte_size, 1'b1};
  endfunction

  task automatic start_copy(input logic [DataW-1:0] src, input logic [DataW-1:0] dst,
                            input logic [DataW-1:0] ctrl);
    reg_access(1'b1, RegSrcAddr, src);
    check_flag("program source", 1'b0, rsp_err);
    reg_access(1'b1, RegDstAddr, dst);
    check_flag("program destination", 1'b0, rsp_err);
    reg_access(1'b1, RegControl, ctrl);
    check_flag("program control", 1'b0, rsp_err);
  endtask

  task automatic wait_idle(input string name);
    int polls;
    polls = 0;
    reg_access(1'b0, RegStatus, '0);
    while (rsp_data[0] && polls < PollLimit) begin
      reg_access(1'b0, RegStatus, '0);
      polls++;
    end
    if (rsp_data[0]) begin
      timeouts++;
      $display("%s: engine still active after %0d status reads", name, polls);
    end
  endtask

  task automatic wait_irq(input logic level, input string name);
    int cycles;
    cycles = 0;
    while (dma_irq !== level && cycles < CycleLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (dma_irq !== level) begin
      timeouts++;
      $display("%s: interrupt did not go to %b within %0d cycles", name, level, cycles);
    end
  endtask

  // --------------------------------------------------------------------------
  // Memory expectations
  // --------------------------------------------------------------------------

  task automatic take_snapshot();
    for (int i = 0; i < Words; i++) begin
      snap[8'(i)]       = i_mem.mem[8'(i)];
      expect_mem[8'(i)] = i_mem.mem[8'(i)];
    end
  endtask

  task automatic expect_word_copy(input int src, input int dst, input int items);
    for (int k = 0; k < items; k++) begin
      expect_mem[8'(dst / 4 + k)] = snap[8'(src / 4 + k)];
    end
  endtask

  // One byte per item, other lanes of the destination word untouched
  task automatic expect_byte_copy(input int src, input int dst, input int items);
    int               sa;
    int               da;
    logic [7:0]       data;
    logic [DataW-1:0] word;
    for (int k = 0; k < items; k++) begin
      sa   = src + k;
      da   = dst + k;
      data = 8'(snap[8'(sa / 4)] >> (8 * (sa % 4)));
      word = expect_mem[8'(da / 4)];
      word = (word & ~(32'hFF << (8 * (da % 4)))) | (32'(data) << (8 * (da % 4)));
      expect_mem[8'(da / 4)] = word;
    end
  endtask

  task automatic compare_memory(input string name);
    for (int i = 0; i < Words; i++) begin
      check_value($sformatf("%s word %0d", name, i), expect_mem[8'(i)], i_mem.mem[8'(i)]);
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    int cycles;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    reg_req  = '0;
    cycles   = 0;
    while (rst_n !== 1'b1 && cycles < CycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      timeouts++;
      $display("Reset was not released within %0d cycles", cycles);
    end
    @(negedge clk);

    // Register access
    reg_access(1'b1, RegSrcAddr, 32'h0000_0ABC);
    check_flag("source write", 1'b0, rsp_err);
    reg_access(1'b1, RegDstAddr, 32'h8000_0F04);
    check_flag("destination write", 1'b0, rsp_err);
    reg_access(1'b0, RegSrcAddr, '0);
    check_value("source readback", 32'h0000_0ABC, rsp_data);
    reg_access(1'b0, RegDstAddr, '0);
    check_value("destination readback", 32'h8000_0F04, rsp_data);
    reg_access(1'b0, 8'h0C, '0);
    check_flag("unmapped read", 1'b1, rsp_err);

    // Word copy with interrupt
    take_snapshot();
    start_copy(32'h000, 32'h200, ctrl_word(8'h10, 8'h20, 11'd8, 1'b1, 1'b1, 1'b1, 1'b0));
    wait_irq(1'b1, "word copy");
    reg_access(1'b0, RegStatus, '0);
    check_status("word copy", 8);
    wait_irq(1'b0, "word copy");
    expect_word_copy('h010, 'h220, 8);
    compare_memory("word copy");

    // Byte copy between unaligned addresses
    take_snapshot();
    start_copy(32'h100, 32'h300, ctrl_word(8'h03, 8'h06, 11'd5, 1'b0, 1'b1, 1'b1, 1'b1));
    wait_idle("byte copy");
    check_status("byte copy", 5);
    expect_byte_copy('h103, 'h306, 5);
    compare_memory("byte copy");

    // Longer copy under random grant delays
    take_snapshot();
    start_copy(32'h040, 32'h280, ctrl_word(8'h00, 8'h00, 11'd20, 1'b0, 1'b1, 1'b1, 1'b0));
    wait_idle("back-pressure copy");
    check_status("back-pressure copy", 20);
    expect_word_copy('h040, 'h280, 20);
    compare_memory("back-pressure copy");

    // Busy rule and abort on a long run
    start_copy(32'h3F0, 32'h3F8, ctrl_word(8'h00, 8'h00, 11'd1000, 1'b0, 1'b0, 1'b0, 1'b0));
    reg_access(1'b0, RegStatus, '0);
    check_flag("long run active", 1'b1, rsp_data[0]);
    reg_access(1'b1, RegSrcAddr, 32'h0000_0123);
    check_flag("write while active", 1'b1, rsp_err);
    reg_access(1'b0, RegSrcAddr, '0);
    check_value("source kept while active", 32'h0000_03F0, rsp_data);
    reg_access(1'b1, RegAbort, '0);
    check_flag("abort write", 1'b0, rsp_err);
    wait_idle("abort");

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* testbench/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  dma_bus_pkg::bus_req_t rd_req_i,
  output dma_bus_pkg::bus_rsp_t rd_rsp_o,
  input  dma_bus_pkg::bus_req_t wr_req_i,
  output dma_bus_pkg::bus_rsp_t wr_rsp_o
);
  import dma_bus_pkg::*;

  localparam int Words = 256;
  localparam int IdxW  = 8;

  logic [DataW-1:0] mem [Words];
  int               seed = 8939;
  logic [1:0]       rd_wait_q;
  logic [1:0]       wr_wait_q;
  logic             rvalid_q;
  logic [DataW-1:0] rdata_q;
  logic             rd_gnt;
  logic             wr_gnt;
  logic [IdxW-1:0]  rd_idx;
  logic [IdxW-1:0]  wr_idx;
  logic [DataW-1:0] lane_mask;

  // Word index from the byte address, wraps at 1 KiB
  assign rd_idx = rd_req_i.addr[9:2];
  assign wr_idx = wr_req_i.addr[9:2];

  // Grant once the drawn delay has run down
  assign rd_gnt = rd_req_i.req && (rd_wait_q == 2'd0);
  assign wr_gnt = wr_req_i.req && (wr_wait_q == 2'd0);

  assign lane_mask = {{8{wr_req_i.be[3]}}, {8{wr_req_i.be[2]}},
                      {8{wr_req_i.be[1]}}, {8{wr_req_i.be[0]}}};

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      rd_wait_q <= 2'd0;
      wr_wait_q <= 2'd0;
      rvalid_q  <= 1'b0;
      // Every word differs, pattern spans the whole index
      for (int i = 0; i < Words; i++) begin
        mem[IdxW'(i)] <= 32'(i + 1) * 32'h9E37_79B9;
      end
    end else begin
      rvalid_q <= rd_gnt;
      if (rd_gnt) begin
        rdata_q   <= mem[rd_idx];
        rd_wait_q <= 2'($random(seed));
      end else if (rd_req_i.req) begin
        rd_wait_q <= rd_wait_q - 2'd1;
      end
      if (wr_gnt) begin
        mem[wr_idx] <= (mem[wr_idx] & ~lane_mask) | (wr_req_i.wdata & lane_mask);
        wr_wait_q   <= 2'($random(seed));
      end else if (wr_req_i.req) begin
        wr_wait_q <= wr_wait_q - 2'd1;
      end
    end
  end

  assign rd_rsp_o = '{gnt: rd_gnt, rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};
  assign wr_rsp_o = '{gnt: wr_gnt, rvalid: 1'b0, err: 1'b0, rdata: '0};

endmodule
